// ==== source/board_input_pkg.sv ====
// ----------------------------------------------------------
// board input package
// widths, vector types and button bit positions shared by
// the joystick capture, mapping and control blocks
// ----------------------------------------------------------
`default_nettype none

package board_input_pkg;

    localparam int NUM_PLAYERS = 4;
    localparam int DIR_BITS    = 4;

    // raw joystick word from the frame with right/left/down/up at bits 3..0
    typedef logic [15:0] board_joy_t;
    // joystick word as seen by the game
    typedef logic [9:0]  game_joy_t;
    typedef logic [DIR_BITS-1:0] dir_t;
    // one bit per player
    typedef logic [NUM_PLAYERS-1:0] player_vec_t;

    // buttons sit above the directions, so these move with the button count
    function automatic int start_bit(input int buttons);
        return 6 + (buttons - 2);
    endfunction

    function automatic int coin_bit(input int buttons);
        return 7 + (buttons - 2);
    endfunction

    function automatic int pause_bit(input int buttons);
        return 8 + (buttons - 2);
    endfunction

endpackage

`default_nettype wire

// ==== source/way_filter.sv ====
// ----------------------------------------------------------
// four-way direction filter
// holds the last legal direction so diagonals are ignored
// when the game expects a four-way stick
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module way_filter (
    input  wire logic                clk_sys,
    input  wire logic                rst,
    input  wire logic                en_4way,
    input  wire board_input_pkg::dir_t dir_in,
    output      board_input_pkg::dir_t dir_out
);
    import board_input_pkg::*;

    dir_t dir_q;
    logic legal;

    // none or a single direction pressed
    assign legal = ($countones(dir_in) <= 1);

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            dir_q <= '0;
        end else if (!en_4way || legal) begin
            dir_q <= dir_in;
        end
    end

    assign dir_out = dir_q;

    // once a legal direction is held under filtering, the next output is legal too.
    // a diagonal caught when the filter turns on may persist until a legal input
    a_stays_4way: assert property (
        @(posedge clk_sys) disable iff (rst)
        (en_4way && $onehot0(dir_out)) |=> $onehot0(dir_out)
    ) else $error("four-way filter produced a diagonal");

endmodule

`default_nettype wire

// ==== source/joy_capture.sv ====
// ----------------------------------------------------------
// joystick capture stage
// registers the four board joysticks, filters the directions
// and keeps the button bits aligned with them
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module joy_capture (
    input  wire logic                       clk_sys,
    input  wire logic                       rst,
    input  wire logic                       en_4way,
    input  wire board_input_pkg::board_joy_t board_joy1,
    input  wire board_input_pkg::board_joy_t board_joy2,
    input  wire board_input_pkg::board_joy_t board_joy3,
    input  wire board_input_pkg::board_joy_t board_joy4,
    output      board_input_pkg::board_joy_t joy_sync1,
    output      board_input_pkg::board_joy_t joy_sync2,
    output      board_input_pkg::board_joy_t joy_sync3,
    output      board_input_pkg::board_joy_t joy_sync4
);
    import board_input_pkg::*;

    localparam int HI_W = $bits(board_joy_t) - DIR_BITS;

    board_joy_t joy_in  [NUM_PLAYERS];
    board_joy_t joy_out [NUM_PLAYERS];

    assign joy_in[0] = board_joy1;
    assign joy_in[1] = board_joy2;
    assign joy_in[2] = board_joy3;
    assign joy_in[3] = board_joy4;

    for (genvar p = 0; p < NUM_PLAYERS; p++) begin : g_player
        dir_t            dir_filt;
        dir_t            dir_q;
        logic [HI_W-1:0] hi_q1;
        logic [HI_W-1:0] hi_q2;

        way_filter u_filter (
            .clk_sys ( clk_sys                   ),
            .rst     ( rst                       ),
            .en_4way ( en_4way                   ),
            .dir_in  ( joy_in[p][DIR_BITS-1:0]   ),
            .dir_out ( dir_filt                  )
        );

        // buttons take two registers to match filter plus capture
        always_ff @(posedge clk_sys) begin
            if (rst) begin
                dir_q <= '0;
                hi_q1 <= '0;
                hi_q2 <= '0;
            end else begin
                dir_q <= dir_filt;
                hi_q1 <= joy_in[p][$bits(board_joy_t)-1:DIR_BITS];
                hi_q2 <= hi_q1;
            end
        end

        assign joy_out[p] = {hi_q2, dir_q};
    end

    assign joy_sync1 = joy_out[0];
    assign joy_sync2 = joy_out[1];
    assign joy_sync3 = joy_out[2];
    assign joy_sync4 = joy_out[3];

endmodule

`default_nettype wire

// ==== source/joy_map.sv ====
// ----------------------------------------------------------
// joystick mapping stage
// merges keyboard keys, applies screen rotation and drives
// the game joysticks, coin and start with optional inversion
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module joy_map #(
    parameter int BUTTONS    = 2,
    parameter bit ACTIVE_LOW = 1'b1
) (
    input  wire logic                        clk_sys,
    input  wire logic                        rst,
    input  wire board_input_pkg::board_joy_t  joy_sync1,
    input  wire board_input_pkg::board_joy_t  joy_sync2,
    input  wire board_input_pkg::board_joy_t  joy_sync3,
    input  wire board_input_pkg::board_joy_t  joy_sync4,
    input  wire board_input_pkg::game_joy_t   key_joy1,
    input  wire board_input_pkg::game_joy_t   key_joy2,
    input  wire board_input_pkg::game_joy_t   key_joy3,
    input  wire board_input_pkg::player_vec_t key_coin,
    input  wire board_input_pkg::player_vec_t key_start,
    input  wire logic                        rot_control,
    input  wire logic                        flip,
    output      board_input_pkg::game_joy_t   game_joy1,
    output      board_input_pkg::game_joy_t   game_joy2,
    output      board_input_pkg::game_joy_t   game_joy3,
    output      board_input_pkg::game_joy_t   game_joy4,
    output      board_input_pkg::player_vec_t game_coin,
    output      board_input_pkg::player_vec_t game_start
);
    import board_input_pkg::*;

    localparam int GW        = $bits(game_joy_t);
    localparam int START_BIT = start_bit(BUTTONS);
    localparam int COIN_BIT  = coin_bit(BUTTONS);

    localparam game_joy_t   JOY_INV = {GW{ACTIVE_LOW}};
    localparam player_vec_t VEC_INV = {NUM_PLAYERS{ACTIVE_LOW}};

    player_vec_t sync_coin;
    player_vec_t sync_start;

    // vertical screens swap the stick axes and flip picks the direction of turn
    function automatic game_joy_t remap(input game_joy_t j, input logic rot, input logic flp);
        game_joy_t r;
        r = j;
        if (rot) begin
            if (flp) begin
                r[3:0] = {j[1], j[0], j[2], j[3]};
            end else begin
                r[3:0] = {j[0], j[1], j[3], j[2]};
            end
        end
        return r;
    endfunction

    assign sync_coin  = {joy_sync4[COIN_BIT], joy_sync3[COIN_BIT],
                         joy_sync2[COIN_BIT], joy_sync1[COIN_BIT]};
    assign sync_start = {joy_sync4[START_BIT], joy_sync3[START_BIT],
                         joy_sync2[START_BIT], joy_sync1[START_BIT]};

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_joy1  <= JOY_INV;
            game_joy2  <= JOY_INV;
            game_joy3  <= JOY_INV;
            game_joy4  <= JOY_INV;
            game_coin  <= VEC_INV;
            game_start <= VEC_INV;
        end else begin
            game_joy1  <= JOY_INV ^ remap(joy_sync1[GW-1:0] | key_joy1, rot_control, flip);
            game_joy2  <= JOY_INV ^ remap(joy_sync2[GW-1:0] | key_joy2, rot_control, flip);
            game_joy3  <= JOY_INV ^ remap(joy_sync3[GW-1:0] | key_joy3, rot_control, flip);
            // no keyboard map for player 4
            game_joy4  <= JOY_INV ^ remap(joy_sync4[GW-1:0], rot_control, flip);
            game_coin  <= VEC_INV ^ (sync_coin | key_coin);
            game_start <= VEC_INV ^ (sync_start | key_start);
        end
    end

    // the game sees released sticks as soon as reset is applied
    a_idle_after_rst: assert property (
        @(posedge clk_sys) rst |=>
            (game_joy1 == JOY_INV) && (game_joy2 == JOY_INV) &&
            (game_joy3 == JOY_INV) && (game_joy4 == JOY_INV)
    ) else $error("joysticks not idle after reset");

endmodule

`default_nettype wire

// ==== source/sys_ctrl.sv ====
// ----------------------------------------------------------
// system controls
// pause toggle, soft reset pulse, graphics layer enables and
// the service key, running beside the joystick pipeline
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sys_ctrl #(
    parameter int BUTTONS    = 2,
    parameter bit ACTIVE_LOW = 1'b1
) (
    input  wire logic                        clk_sys,
    input  wire logic                        rst,
    input  wire board_input_pkg::board_joy_t  joy_sync1,
    input  wire board_input_pkg::board_joy_t  joy_sync2,
    input  wire logic                        key_pause,
    input  wire logic                        key_reset,
    input  wire logic                        key_service,
    input  wire board_input_pkg::player_vec_t key_gfx,
    input  wire logic                        osd_pause,
    input  wire logic                        downloading,
    output      logic                        game_pause,
    output      logic                        soft_rst,
    output      logic                        game_service,
    output      board_input_pkg::player_vec_t gfx_en
);
    import board_input_pkg::*;

    localparam int PAUSE_BIT = pause_bit(BUTTONS);

    logic        joy_pause;
    logic        last_pause;
    logic        last_joy_pause;
    logic        last_reset;
    logic        last_osd_pause;
    player_vec_t last_gfx;
    logic        pause_rise;
    logic        osd_change;

    // either of the first two players can pause
    assign joy_pause  = joy_sync1[PAUSE_BIT] | joy_sync2[PAUSE_BIT];
    assign pause_rise = (key_pause & ~last_pause) | (joy_pause & ~last_joy_pause);
    assign osd_change = osd_pause ^ last_osd_pause;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_pause     <= 1'b0;
            last_joy_pause <= 1'b0;
            last_reset     <= 1'b0;
            last_osd_pause <= 1'b0;
            last_gfx       <= '0;
            game_pause     <= 1'b0;
            soft_rst       <= 1'b0;
            gfx_en         <= '1;
            game_service   <= ACTIVE_LOW;
        end else begin
            last_pause     <= key_pause;
            last_joy_pause <= joy_pause;
            last_reset     <= key_reset;
            last_osd_pause <= osd_pause;
            last_gfx       <= key_gfx;

            soft_rst     <= key_reset & ~last_reset;
            gfx_en       <= gfx_en ^ (key_gfx & ~last_gfx);
            game_service <= key_service ^ ACTIVE_LOW;

            // menu setting wins over a button toggle
            if (downloading) begin
                game_pause <= 1'b0;
            end else if (osd_change) begin
                game_pause <= osd_pause;
            end else if (pause_rise) begin
                game_pause <= ~game_pause;
            end
        end
    end

    // held reset key must not retrigger the game reset
    a_soft_rst_pulse: assert property (
        @(posedge clk_sys) disable iff (rst)
        soft_rst |=> !soft_rst
    ) else $error("soft reset longer than one cycle");

endmodule

`default_nettype wire

// ==== source/input_board.sv ====
// ----------------------------------------------------------
// player input board
// capture and mapping stages for four joysticks, with the
// system control block alongside
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module input_board #(
    parameter int BUTTONS    = 2,
    parameter bit ACTIVE_LOW = 1'b1
) (
    input  wire logic                        clk_sys,
    input  wire logic                        rst,
    input  wire logic                        en_4way,
    input  wire board_input_pkg::board_joy_t  board_joystick1,
    input  wire board_input_pkg::board_joy_t  board_joystick2,
    input  wire board_input_pkg::board_joy_t  board_joystick3,
    input  wire board_input_pkg::board_joy_t  board_joystick4,
    input  wire board_input_pkg::game_joy_t   key_joy1,
    input  wire board_input_pkg::game_joy_t   key_joy2,
    input  wire board_input_pkg::game_joy_t   key_joy3,
    input  wire board_input_pkg::player_vec_t key_coin,
    input  wire board_input_pkg::player_vec_t key_start,
    input  wire logic                        rot_control,
    input  wire logic                        flip,
    input  wire logic                        key_pause,
    input  wire logic                        key_reset,
    input  wire logic                        key_service,
    input  wire board_input_pkg::player_vec_t key_gfx,
    input  wire logic                        osd_pause,
    input  wire logic                        downloading,
    output      board_input_pkg::game_joy_t   game_joystick1,
    output      board_input_pkg::game_joy_t   game_joystick2,
    output      board_input_pkg::game_joy_t   game_joystick3,
    output      board_input_pkg::game_joy_t   game_joystick4,
    output      board_input_pkg::player_vec_t game_coin,
    output      board_input_pkg::player_vec_t game_start,
    output      logic                        game_pause,
    output      logic                        soft_rst,
    output      logic                        game_service,
    output      board_input_pkg::player_vec_t gfx_en
);
    import board_input_pkg::*;

    // board joysticks two cycles after sampling
    board_joy_t joy_sync1;
    board_joy_t joy_sync2;
    board_joy_t joy_sync3;
    board_joy_t joy_sync4;

    joy_capture u_capture (
        .clk_sys    ( clk_sys         ),
        .rst        ( rst             ),
        .en_4way    ( en_4way         ),
        .board_joy1 ( board_joystick1 ),
        .board_joy2 ( board_joystick2 ),
        .board_joy3 ( board_joystick3 ),
        .board_joy4 ( board_joystick4 ),
        .joy_sync1  ( joy_sync1       ),
        .joy_sync2  ( joy_sync2       ),
        .joy_sync3  ( joy_sync3       ),
        .joy_sync4  ( joy_sync4       )
    );

    joy_map #(
        .BUTTONS    ( BUTTONS    ),
        .ACTIVE_LOW ( ACTIVE_LOW )
    ) u_map (
        .clk_sys     ( clk_sys        ),
        .rst         ( rst            ),
        .joy_sync1   ( joy_sync1      ),
        .joy_sync2   ( joy_sync2      ),
        .joy_sync3   ( joy_sync3      ),
        .joy_sync4   ( joy_sync4      ),
        .key_joy1    ( key_joy1       ),
        .key_joy2    ( key_joy2       ),
        .key_joy3    ( key_joy3       ),
        .key_coin    ( key_coin       ),
        .key_start   ( key_start      ),
        .rot_control ( rot_control    ),
        .flip        ( flip           ),
        .game_joy1   ( game_joystick1 ),
        .game_joy2   ( game_joystick2 ),
        .game_joy3   ( game_joystick3 ),
        .game_joy4   ( game_joystick4 ),
        .game_coin   ( game_coin      ),
        .game_start  ( game_start     )
    );

    // only players 1 and 2 carry a pause button
    sys_ctrl #(
        .BUTTONS    ( BUTTONS    ),
        .ACTIVE_LOW ( ACTIVE_LOW )
    ) u_ctrl (
        .clk_sys      ( clk_sys      ),
        .rst          ( rst          ),
        .joy_sync1    ( joy_sync1    ),
        .joy_sync2    ( joy_sync2    ),
        .key_pause    ( key_pause    ),
        .key_reset    ( key_reset    ),
        .key_service  ( key_service  ),
        .key_gfx      ( key_gfx      ),
        .osd_pause    ( osd_pause    ),
        .downloading  ( downloading  ),
        .game_pause   ( game_pause   ),
        .soft_rst     ( soft_rst     ),
        .game_service ( game_service ),
        .gfx_en       ( gfx_en       )
    );

endmodule

`default_nettype wire

// ==== bench/clk_gen.sv ====
// ----------------------------------------------------------
// testbench clock and reset
// 20 ns clock with reset held for the first two rising edges
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_sys,
    output logic rst
);

    initial begin
        clk_sys = 1'b0;
        forever #(HALF_PERIOD) clk_sys = ~clk_sys;
    end

    // release lines up with the stimulus drive point
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_sys);
        #2;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== bench/tb_input_board.sv ====
// ----------------------------------------------------------
// testbench for the player input board
// random stimulus checked cycle by cycle against a model of
// the joystick pipeline and the system controls
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_input_board;
    import board_input_pkg::*;

    localparam int          NUM_CYCLES     = 4000;
    localparam int          DIRECT_CYCLES  = 1000;
    localparam int          TIMEOUT_CYCLES = NUM_CYCLES + 1000;
    localparam logic [31:0] SEED           = 32'h66073b65;
    localparam bit          ACTIVE_LOW     = 1'b1;
    localparam int          BUTTONS        = 2;
    // button positions above the four directions
    localparam int          START_POS      = 6 + (BUTTONS - 2);
    localparam int          COIN_POS       = 7 + (BUTTONS - 2);
    localparam int          PAUSE_POS      = 8 + (BUTTONS - 2);
    localparam int          GW             = $bits(game_joy_t);
    localparam game_joy_t   JOY_IDLE       = {GW{ACTIVE_LOW}};
    localparam player_vec_t VEC_IDLE       = {NUM_PLAYERS{ACTIVE_LOW}};

    logic        clk_sys;
    logic        rst;
    logic        en_4way;
    logic        rot_control;
    logic        flip;
    logic        key_pause;
    logic        key_reset;
    logic        key_service;
    logic        osd_pause;
    logic        downloading;
    board_joy_t  board_in [NUM_PLAYERS];
    game_joy_t   key_joy_in [3];
    player_vec_t key_coin;
    player_vec_t key_start;
    player_vec_t key_gfx;
    game_joy_t   joy_out [NUM_PLAYERS];
    player_vec_t game_coin;
    player_vec_t game_start;
    player_vec_t gfx_en;
    logic        game_pause;
    logic        soft_rst;
    logic        game_service;

    // applied inputs by cycle with index 0 holding the reset state
    board_joy_t  board_h [NUM_PLAYERS][NUM_CYCLES+1];
    dir_t        filt_h  [NUM_PLAYERS][NUM_CYCLES+1];
    game_joy_t   keyj_h  [3][NUM_CYCLES+1];
    player_vec_t coin_h    [NUM_CYCLES+1];
    player_vec_t start_h   [NUM_CYCLES+1];
    player_vec_t gfx_h     [NUM_CYCLES+1];
    logic        rot_h     [NUM_CYCLES+1];
    logic        flip_h    [NUM_CYCLES+1];
    logic        pause_h   [NUM_CYCLES+1];
    logic        reset_h   [NUM_CYCLES+1];
    logic        service_h [NUM_CYCLES+1];
    logic        osd_h     [NUM_CYCLES+1];
    logic        dl_h      [NUM_CYCLES+1];

    logic        exp_pause;
    player_vec_t exp_gfx;
    int          dl_left;
    int          mismatches;
    int          cycle_count = 0;

    clk_gen #(
        .HALF_PERIOD  ( 10 ),
        .RESET_CYCLES ( 2  )
    ) u_clk (
        .clk_sys ( clk_sys ),
        .rst     ( rst     )
    );

    input_board uut (
        .clk_sys         ( clk_sys       ),
        .rst             ( rst           ),
        .en_4way         ( en_4way       ),
        .board_joystick1 ( board_in[0]   ),
        .board_joystick2 ( board_in[1]   ),
        .board_joystick3 ( board_in[2]   ),
        .board_joystick4 ( board_in[3]   ),
        .key_joy1        ( key_joy_in[0] ),
        .key_joy2        ( key_joy_in[1] ),
        .key_joy3        ( key_joy_in[2] ),
        .key_coin        ( key_coin      ),
        .key_start       ( key_start     ),
        .rot_control     ( rot_control   ),
        .flip            ( flip          ),
        .key_pause       ( key_pause     ),
        .key_reset       ( key_reset     ),
        .key_service     ( key_service   ),
        .key_gfx         ( key_gfx       ),
        .osd_pause       ( osd_pause     ),
        .downloading     ( downloading   ),
        .game_joystick1  ( joy_out[0]    ),
        .game_joystick2  ( joy_out[1]    ),
        .game_joystick3  ( joy_out[2]    ),
        .game_joystick4  ( joy_out[3]    ),
        .game_coin       ( game_coin     ),
        .game_start      ( game_start    ),
        .game_pause      ( game_pause    ),
        .soft_rst        ( soft_rst      ),
        .game_service    ( game_service  ),
        .gfx_en          ( gfx_en        )
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_joy(input string name, input game_joy_t got, input game_joy_t exp);
        if (got !== exp) begin
            mismatches++;
            abort_run($sformatf("Fail at %0d ns: %s expected %h got %h", $time, name, exp, got));
        end
    endtask

    task automatic check_vec(input string name, input player_vec_t got, input player_vec_t exp);
        if (got !== exp) begin
            mismatches++;
            abort_run($sformatf("Fail at %0d ns: %s expected %h got %h", $time, name, exp, got));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            abort_run($sformatf("Fail at %0d ns: %s expected %b got %b", $time, name, exp, got));
        end
    endtask

    // mostly idle, single and diagonal directions, so both filter paths get exercised
    function automatic dir_t random_dir();
        int   sel;
        int   first;
        int   second;
        dir_t d;
        sel = int'($urandom % 4);
        first = int'($urandom % 4);
        second = (first + 1 + int'($urandom % 3)) % 4;
        case (sel)
            0:       d = '0;
            1:       d = dir_t'(1 << first);
            2:       d = dir_t'((1 << first) | (1 << second));
            default: d = dir_t'($urandom);
        endcase
        return d;
    endfunction

    function automatic dir_t filter_step(input dir_t held, input dir_t dir, input logic en);
        int pressed;
        int b;
        pressed = 0;
        for (b = 0; b < DIR_BITS; b++) begin
            if (dir[b]) begin
                pressed++;
            end
        end
        if (!en || pressed <= 1) begin
            return dir;
        end
        return held;
    endfunction

    function automatic game_joy_t rotate_dirs(input game_joy_t j, input logic rot, input logic flp);
        game_joy_t r;
        r = j;
        if (rot && !flp) begin
            r[3:0] = {j[0], j[1], j[3], j[2]};
        end else if (rot && flp) begin
            r[3:0] = {j[1], j[0], j[2], j[3]};
        end
        return r;
    endfunction

    // capture stage word that the mapping stage samples at edge n
    function automatic board_joy_t sync_word(input int p, input int n);
        board_joy_t w;
        w = '0;
        if (n >= 2) begin
            w = board_h[p][n-2];
            w[DIR_BITS-1:0] = filt_h[p][n-2];
        end
        return w;
    endfunction

    function automatic logic joy_pause_at(input int n);
        board_joy_t w1;
        board_joy_t w2;
        w1 = sync_word(0, n);
        w2 = sync_word(1, n);
        return w1[PAUSE_POS] | w2[PAUSE_POS];
    endfunction

    task automatic apply_inputs(input int n);
        board_joy_t word;
        logic       directed;
        int         p;
        int         k;
        directed = (n <= DIRECT_CYCLES);
        if (directed) begin
            en_4way = 1'b1;
            rot_control = 1'b0;
            flip = 1'b0;
        end else begin
            if ($urandom % 50 == 0) begin
                en_4way = ~en_4way;
            end
            if ($urandom % 16 == 0) begin
                rot_control = 1'($urandom);
                flip = 1'($urandom);
            end
        end
        for (p = 0; p < NUM_PLAYERS; p++) begin
            word = board_joy_t'($urandom);
            word[DIR_BITS-1:0] = random_dir();
            // sparse so joystick pause edges stay apart
            word[PAUSE_POS] = ($urandom % 8 == 0);
            board_in[p] = word;
            board_h[p][n] = word;
            filt_h[p][n] = filter_step(filt_h[p][n-1], word[DIR_BITS-1:0], en_4way);
        end
        for (k = 0; k < 3; k++) begin
            if (!directed && ($urandom % 3 == 0)) begin
                key_joy_in[k] = game_joy_t'($urandom);
            end else begin
                key_joy_in[k] = '0;
            end
            keyj_h[k][n] = key_joy_in[k];
        end
        key_coin = directed ? '0 : player_vec_t'($urandom & $urandom);
        key_start = directed ? '0 : player_vec_t'($urandom & $urandom);
        key_gfx = player_vec_t'($urandom & $urandom & $urandom);
        key_pause = ($urandom % 6 == 0);
        key_reset = ($urandom % 4 == 0);
        key_service = 1'($urandom);
        if ($urandom % 25 == 0) begin
            osd_pause = ~osd_pause;
        end
        // download bursts of 10 to 39 cycles
        if (dl_left > 0) begin
            downloading = 1'b1;
            dl_left--;
        end else begin
            downloading = 1'b0;
            if ($urandom % 150 == 0) begin
                dl_left = 10 + int'($urandom % 30);
            end
        end
        coin_h[n] = key_coin;
        start_h[n] = key_start;
        gfx_h[n] = key_gfx;
        rot_h[n] = rot_control;
        flip_h[n] = flip;
        pause_h[n] = key_pause;
        reset_h[n] = key_reset;
        service_h[n] = key_service;
        osd_h[n] = osd_pause;
        dl_h[n] = downloading;
    endtask

    task automatic check_reset_state();
        int p;
        for (p = 0; p < NUM_PLAYERS; p++) begin
            check_joy($sformatf("game_joystick%0d after reset", p + 1), joy_out[p], JOY_IDLE);
        end
        check_vec("game_coin after reset", game_coin, VEC_IDLE);
        check_vec("game_start after reset", game_start, VEC_IDLE);
        check_vec("gfx_en after reset", gfx_en, '1);
        check_bit("game_pause after reset", game_pause, 1'b0);
        check_bit("soft_rst after reset", soft_rst, 1'b0);
        check_bit("game_service after reset", game_service, ACTIVE_LOW);
    endtask

    task automatic check_cycle(input int n);
        board_joy_t  sync;
        game_joy_t   merged;
        player_vec_t exp_coin;
        player_vec_t exp_start;
        logic        pause_edge;
        int          p;
        exp_coin = '0;
        exp_start = '0;
        for (p = 0; p < NUM_PLAYERS; p++) begin
            sync = sync_word(p, n);
            merged = sync[GW-1:0];
            // player 4 has no keyboard map
            if (p < 3) begin
                merged = merged | keyj_h[p][n];
            end
            check_joy($sformatf("game_joystick%0d", p + 1), joy_out[p],
                      JOY_IDLE ^ rotate_dirs(merged, rot_h[n], flip_h[n]));
            exp_coin[p] = sync[COIN_POS] | coin_h[n][p];
            exp_start[p] = sync[START_POS] | start_h[n][p];
        end
        check_vec("game_coin", game_coin, VEC_IDLE ^ exp_coin);
        check_vec("game_start", game_start, VEC_IDLE ^ exp_start);

        pause_edge = (pause_h[n] & ~pause_h[n-1]) | (joy_pause_at(n) & ~joy_pause_at(n - 1));
        if (dl_h[n]) begin
            exp_pause = 1'b0;
        end else if (osd_h[n] != osd_h[n-1]) begin
            exp_pause = osd_h[n];
        end else if (pause_edge) begin
            exp_pause = ~exp_pause;
        end
        exp_gfx = exp_gfx ^ (gfx_h[n] & ~gfx_h[n-1]);
        check_bit("game_pause", game_pause, exp_pause);
        check_bit("soft_rst", soft_rst, reset_h[n] & ~reset_h[n-1]);
        check_bit("game_service", game_service, service_h[n] ^ ACTIVE_LOW);
        check_vec("gfx_en", gfx_en, exp_gfx);
    endtask

    always @(posedge clk_sys) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout: test did not finish within %0d cycles",
                                TIMEOUT_CYCLES));
        end
    end

    initial begin
        int p;
        void'($urandom(SEED));
        en_4way = 1'b0;
        rot_control = 1'b0;
        flip = 1'b0;
        key_pause = 1'b0;
        key_reset = 1'b0;
        key_service = 1'b0;
        osd_pause = 1'b0;
        downloading = 1'b0;
        key_coin = '0;
        key_start = '0;
        key_gfx = '0;
        for (p = 0; p < NUM_PLAYERS; p++) begin
            board_in[p] = '0;
            board_h[p][0] = '0;
            filt_h[p][0] = '0;
        end
        for (p = 0; p < 3; p++) begin
            key_joy_in[p] = '0;
            keyj_h[p][0] = '0;
        end
        coin_h[0] = '0;
        start_h[0] = '0;
        gfx_h[0] = '0;
        rot_h[0] = 1'b0;
        flip_h[0] = 1'b0;
        pause_h[0] = 1'b0;
        reset_h[0] = 1'b0;
        service_h[0] = 1'b0;
        osd_h[0] = 1'b0;
        dl_h[0] = 1'b0;
        exp_pause = 1'b0;
        exp_gfx = '1;
        dl_left = 0;
        mismatches = 0;

        @(posedge clk_sys);
        wait (rst === 1'b0);
        check_reset_state();
        for (int n = 1; n <= NUM_CYCLES; n++) begin
            apply_inputs(n);
            @(posedge clk_sys);
            #2;
            check_cycle(n);
        end

        if (mismatches == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            abort_run($sformatf("%0d mismatches recorded", mismatches));
        end
    end

endmodule

`default_nettype wire

// ==== compile.f ====
source/board_input_pkg.sv
source/way_filter.sv
source/joy_capture.sv
source/joy_map.sv
source/sys_ctrl.sv
source/input_board.sv
bench/clk_gen.sv
bench/tb_input_board.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_input_board
FILELIST   := compile.f
OBJ_DIR    := obj_dir
PASS_TEXT  := Verification passed
COMMON     := --timing --assert --timescale 1ns/1ps
LINT_FLAGS := --lint-only $(COMMON)
SIM_FLAGS  := --binary $(COMMON)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
